//--- tb.f
+incdir+rtl
+incdir+verif
rtl/cop_pkg.sv
rtl/cop_cen.sv
rtl/cop_mcu_bridge.sv
rtl/cop_glue.sv
verif/tb_cop_glue.sv

//--- verif/cop_ref.svh
/* Reference model for the coprocessor glue
   Next-state and expected-value functions for enables, bridge and status dump */
`ifndef COP_REF_SVH
`define COP_REF_SVH

// Strobe is high after every div-th rising edge since reset release
function automatic logic cen_expect(int edges, int div);
    return (edges > 0) && ((edges % div) == 0);
endfunction

// Read-low has priority over read-high
function automatic byte_t p0_i_next(byte_t cur, byte_t p2, word_t din);
    if (!p2[`COP_P2_RDLO]) begin
        return din[7:0];
    end
    if (!p2[`COP_P2_RDHI]) begin
        return din[15:8];
    end
    return cur;
endfunction

function automatic word_t mcu_dout_next(word_t cur, byte_t p2, byte_t p0);
    word_t nxt;
    nxt = cur;
    if (!p2[`COP_P2_WRHI]) begin
        nxt[15:8] = p0;
    end
    if (!p2[`COP_P2_WRLO]) begin
        nxt[7:0] = p0;
    end
    return nxt;
endfunction

// Acknowledge wins over a new select edge
function automatic logic int1n_next(logic cur, logic sel0_prev, logic sel0_now, byte_t p2);
    if (!p2[`COP_P2_IRQ_ACK]) begin
        return 1'b1;
    end
    if (sel0_now && !sel0_prev) begin
        return 1'b0;
    end
    return cur;
endfunction

function automatic byte_t p3_i_expect(sec_t s, byte_t p3);
    return {s[5:3], p3[4:0]};
endfunction

function automatic byte_t st_dout_next(byte_t addr, byte_t video, byte_t latch,
                                       byte_t main, byte_t snd);
    case (addr[7:6])
        2'd0:    return video;
        2'd1:    return latch;
        2'd2:    return main;
        default: return snd;
    endcase
endfunction

`endif

//--- verif/tb_cop_glue.sv
/* Testbench for the coprocessor glue top level
   Random stimulus per feature, checked every cycle against a reference model */
`timescale 1ns/1ps
`include "cop_defines.svh"

module tb_cop_glue
    import cop_pkg::*;
();

    `include "cop_ref.svh"

    localparam int RESET_CYCLES = 2;
    localparam int N_WR = 400;
    localparam int N_RD = 400;
    localparam int N_IRQ = 400;
    localparam int N_COMB = 300;
    localparam int N_ST = 500;
    localparam int TAIL = 4;
    localparam int TEST_CYCLES = RESET_CYCLES + N_WR + N_RD + N_IRQ + N_COMB + N_ST + TAIL;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES * 3 / 2;

    logic    clk;
    logic    rst24;
    logic    cen_opl;
    logic    cen_opn;
    logic    cen_mcu;
    byte_t   p0_o;
    byte_t   p1_o;
    byte_t   p2_o;
    byte_t   p3_o;
    byte_t   p0_i;
    byte_t   p3_i;
    logic    int1n;
    word_t   cpu_din;
    sec_t    sec;
    logic    mcu_sel2;
    word_t   mcu_dout;
    flag2_t  sndflag;
    flag2_t  b1flg;
    logic    b0flg;
    flag2_t  mixflg;
    crback_t crback;
    byte_t   st_addr;
    byte_t   st_video;
    byte_t   st_main;
    byte_t   st_snd;
    byte_t   snd_latch;
    byte_t   st_dout;

    integer seed;
    int     cycle_count;

    // Shadow state of the reference model
    int     m_edges;
    byte_t  m_p0_i;
    word_t  m_dout;
    logic   m_int1n;
    logic   m_sel0_l;
    byte_t  m_st_dout;

    cop_glue i_dut (
        .clk       ( clk       ),
        .rst24     ( rst24     ),
        .cen_opl   ( cen_opl   ),
        .cen_opn   ( cen_opn   ),
        .cen_mcu   ( cen_mcu   ),
        .p0_o      ( p0_o      ),
        .p1_o      ( p1_o      ),
        .p2_o      ( p2_o      ),
        .p3_o      ( p3_o      ),
        .p0_i      ( p0_i      ),
        .p3_i      ( p3_i      ),
        .int1n     ( int1n     ),
        .cpu_din   ( cpu_din   ),
        .sec       ( sec       ),
        .mcu_sel2  ( mcu_sel2  ),
        .mcu_dout  ( mcu_dout  ),
        .sndflag   ( sndflag   ),
        .b1flg     ( b1flg     ),
        .b0flg     ( b0flg     ),
        .mixflg    ( mixflg    ),
        .crback    ( crback    ),
        .st_addr   ( st_addr   ),
        .st_video  ( st_video  ),
        .st_main   ( st_main   ),
        .st_snd    ( st_snd    ),
        .snd_latch ( snd_latch ),
        .st_dout   ( st_dout   )
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic reset_model();
        m_edges   = 0;
        m_p0_i    = '0;
        m_dout    = '0;
        m_int1n   = 1'b1;
        m_sel0_l  = 1'b0;
        m_st_dout = '0;
    endtask

    task automatic check_outputs();
        check_value("cen_opl", cen_opl, cen_expect(m_edges, `COP_DIV_OPL));
        check_value("cen_opn", cen_opn, cen_expect(m_edges, `COP_DIV_OPN));
        check_value("cen_mcu", cen_mcu, cen_expect(m_edges, `COP_DIV_MCU));
        check_value("p0_i", p0_i, m_p0_i);
        check_value("mcu_dout", mcu_dout, m_dout);
        check_value("int1n", int1n, m_int1n);
        check_value("st_dout", st_dout, m_st_dout);
        check_value("p3_i", p3_i, p3_i_expect(sec, p3_o));
        check_value("mcu_sel2", mcu_sel2, p2_o[`COP_P2_SEL2]);
        check_value("sndflag", sndflag, p1_o[6:5]);
        check_value("b1flg", b1flg, p1_o[4:3]);
        check_value("b0flg", b0flg, p1_o[2]);
        check_value("mixflg", mixflg, p1_o[1:0]);
        check_value("crback", crback, p3_o[2:0]);
    endtask

    task automatic step_model();
        m_edges   = m_edges + 1;
        m_p0_i    = p0_i_next(m_p0_i, p2_o, cpu_din);
        m_dout    = mcu_dout_next(m_dout, p2_o, p0_o);
        m_int1n   = int1n_next(m_int1n, m_sel0_l, sec[0], p2_o);
        m_sel0_l  = sec[0];
        m_st_dout = st_dout_next(st_addr, st_video, snd_latch, st_main, st_snd);
    endtask

    // Outputs are compared before the model takes this edge
    // First edge after release sees the reset values
    always @(posedge clk) begin
        if (rst24) begin
            reset_model();
        end else begin
            check_outputs();
            step_model();
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("Something failed");
            $fatal(1);
        end
    end

    // Write strobes on bits 7 and 6 only
    task automatic run_writes();
        for (int i = 0; i < N_WR; i++) begin
            @(negedge clk);
            p0_o = $random(seed);
            p2_o = {2'($random(seed)), 6'h3f};
        end
    endtask

    // Read strobes on bits 5 and 4 only
    task automatic run_reads();
        for (int i = 0; i < N_RD; i++) begin
            @(negedge clk);
            cpu_din = $random(seed);
            p2_o    = {2'b11, 2'($random(seed)), 4'hf};
        end
    endtask

    task automatic drive_irq(logic sel0, logic ack_n);
        @(negedge clk);
        sec[0] = sel0;
        p2_o   = 8'hff;
        p2_o[`COP_P2_IRQ_ACK] = ack_n;
    endtask

    task automatic run_interrupts();
        // Edge together with acknowledge, then a plain edge and its release
        drive_irq(1'b0, 1'b1);
        drive_irq(1'b1, 1'b0);
        drive_irq(1'b0, 1'b1);
        drive_irq(1'b1, 1'b1);
        drive_irq(1'b1, 1'b1);
        drive_irq(1'b1, 1'b0);
        drive_irq(1'b0, 1'b1);
        for (int i = 7; i < N_IRQ; i++) begin
            drive_irq($random(seed), (($random(seed) & 3) != 0));
        end
    endtask

    task automatic run_comb();
        for (int i = 0; i < N_COMB; i++) begin
            @(negedge clk);
            p1_o = $random(seed);
            p2_o = $random(seed);
            p3_o = $random(seed);
            sec  = $random(seed);
        end
    endtask

    task automatic run_status();
        for (int i = 0; i < N_ST; i++) begin
            @(negedge clk);
            st_addr   = $random(seed);
            st_video  = $random(seed);
            st_main   = $random(seed);
            st_snd    = $random(seed);
            snd_latch = $random(seed);
        end
    endtask

    initial begin
        seed        = 3;
        cycle_count = 0;
        reset_model();
        rst24     = 1'b1;
        p0_o      = '0;
        p1_o      = '0;
        p2_o      = 8'hff;
        p3_o      = '0;
        cpu_din   = '0;
        sec       = '0;
        st_addr   = '0;
        st_video  = '0;
        st_main   = '0;
        st_snd    = '0;
        snd_latch = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst24 = 1'b0;
        run_writes();
        run_reads();
        run_interrupts();
        run_comb();
        run_status();
        repeat (TAIL) @(negedge clk);
        $display("Everything OK");
        $finish;
    end

endmodule

//--- rtl/cop_glue.sv
/* Coprocessor glue top level
   Clock enables, MCU port bridge and the registered status dump selector */
`timescale 1ns/1ps
`include "cop_defines.svh"

module cop_glue
    import cop_pkg::*;
(
    input  logic    clk,
    input  logic    rst24,

    // Clock enables
    output logic    cen_opl,
    output logic    cen_opn,
    output logic    cen_mcu,

    // MCU ports
    input  byte_t   p0_o,
    input  byte_t   p1_o,
    input  byte_t   p2_o,
    input  byte_t   p3_o,
    output byte_t   p0_i,
    output byte_t   p3_i,
    output logic    int1n,

    // Main CPU latch
    input  word_t   cpu_din,
    input  sec_t    sec,
    output logic    mcu_sel2,
    output word_t   mcu_dout,

    // ROM banks
    output flag2_t  sndflag,
    output flag2_t  b1flg,
    output logic    b0flg,
    output flag2_t  mixflg,
    output crback_t crback,

    // Status dump
    input  byte_t   st_addr,
    input  byte_t   st_video,
    input  byte_t   st_main,
    input  byte_t   st_snd,
    input  byte_t   snd_latch,
    output byte_t   st_dout
);

    st_sel_t st_sel;

    cop_cen u_cen (
        .clk     ( clk     ),
        .rst24   ( rst24   ),
        .cen_opl ( cen_opl ),
        .cen_opn ( cen_opn ),
        .cen_mcu ( cen_mcu )
    );

    cop_mcu_bridge u_bridge (
        .clk      ( clk      ),
        .rst24    ( rst24    ),
        .p0_o     ( p0_o     ),
        .p1_o     ( p1_o     ),
        .p2_o     ( p2_o     ),
        .p3_o     ( p3_o     ),
        .cpu_din  ( cpu_din  ),
        .sec      ( sec      ),
        .p0_i     ( p0_i     ),
        .p3_i     ( p3_i     ),
        .int1n    ( int1n    ),
        .mcu_sel2 ( mcu_sel2 ),
        .mcu_dout ( mcu_dout ),
        .sndflag  ( sndflag  ),
        .b1flg    ( b1flg    ),
        .b0flg    ( b0flg    ),
        .mixflg   ( mixflg   ),
        .crback   ( crback   )
    );

    assign st_sel = st_addr[`COP_ST_SEL_MSB:`COP_ST_SEL_LSB];

    // Status dump, one cycle behind the address
    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            st_dout <= '0;
        end else begin
            case (st_sel)
                2'd0:    st_dout <= st_video;
                2'd1:    st_dout <= snd_latch;
                2'd2:    st_dout <= st_main;
                default: st_dout <= st_snd;
            endcase
        end
    end

endmodule

//--- rtl/cop_mcu_bridge.sv
/* Bridge between the sub-MCU ports and the main CPU latch
   Byte latches both ways, interrupt request and ROM bank flag decoding */
`timescale 1ns/1ps
`include "cop_defines.svh"

module cop_mcu_bridge
    import cop_pkg::*;
(
    input  logic    clk,
    input  logic    rst24,

    // MCU port outputs
    input  byte_t   p0_o,
    input  byte_t   p1_o,
    input  byte_t   p2_o,
    input  byte_t   p3_o,

    // Main CPU side
    input  word_t   cpu_din,
    input  sec_t    sec,

    // Back into the MCU
    output byte_t   p0_i,
    output byte_t   p3_i,
    output logic    int1n,

    // To the main CPU
    output logic    mcu_sel2,
    output word_t   mcu_dout,

    // ROM bank and colour flags
    output flag2_t  sndflag,
    output flag2_t  b1flg,
    output logic    b0flg,
    output flag2_t  mixflg,
    output crback_t crback
);

    logic rd_hi;
    logic rd_lo;
    logic wr_hi;
    logic wr_lo;
    logic irq_ack;
    logic sel0_l;
    logic sel0_rise;

    // Port 2 strobes are active low
    assign rd_hi   = ~p2_o[`COP_P2_RDHI];
    assign rd_lo   = ~p2_o[`COP_P2_RDLO];
    assign wr_hi   = ~p2_o[`COP_P2_WRHI];
    assign wr_lo   = ~p2_o[`COP_P2_WRLO];
    assign irq_ack = ~p2_o[`COP_P2_IRQ_ACK];

    assign sel0_rise = sec[0] & ~sel0_l;

    // Select lines 5:3 replace the top of port 3
    assign p3_i = {sec[5:3], p3_o[4:0]};

    assign mcu_sel2 = p2_o[`COP_P2_SEL2];

    // Port 1 packs the bank flags, high to low
    assign {sndflag, b1flg, b0flg, mixflg} = p1_o[6:0];
    assign crback = p3_o[2:0];

    // External interrupt
    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            sel0_l <= 1'b0;
            int1n  <= 1'b1;
        end else begin
            sel0_l <= sec[0];
            // Acknowledge beats a new request
            if (irq_ack) begin
                int1n <= 1'b1;
            end else if (sel0_rise) begin
                int1n <= 1'b0;
            end
        end
    end

    // MCU reads one byte of the CPU word
    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            p0_i <= '0;
        end else begin
            if (rd_lo) begin
                p0_i <= cpu_din[7:0];
            end else if (rd_hi) begin
                p0_i <= cpu_din[15:8];
            end
        end
    end

    // MCU writes the word to the CPU a byte at a time
    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            mcu_dout <= '0;
        end else begin
            if (wr_hi) begin
                mcu_dout[15:8] <= p0_o;
            end
            if (wr_lo) begin
                mcu_dout[7:0] <= p0_o;
            end
        end
    end

endmodule

//--- rtl/cop_cen.sv
/* Clock enable generator
   Derives the OPL, OPN and MCU strobes from the 24 MHz clock */
`timescale 1ns/1ps
`include "cop_defines.svh"

module cop_cen (
    input  logic clk,
    input  logic rst24,
    output logic cen_opl,
    output logic cen_opn,
    output logic cen_mcu
);

    localparam int OPL_W = $clog2(`COP_DIV_OPL);
    localparam int OPN_W = $clog2(`COP_DIV_OPN);
    localparam int MCU_W = $clog2(`COP_DIV_MCU);

    // Last count before each counter wraps
    localparam logic [OPL_W-1:0] OPL_LAST = OPL_W'(`COP_DIV_OPL - 1);
    localparam logic [OPN_W-1:0] OPN_LAST = OPN_W'(`COP_DIV_OPN - 1);
    localparam logic [MCU_W-1:0] MCU_LAST = MCU_W'(`COP_DIV_MCU - 1);

    logic [OPL_W-1:0] cnt_opl;
    logic [OPN_W-1:0] cnt_opn;
    logic [MCU_W-1:0] cnt_mcu;

    // OPL at 3 MHz
    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            cnt_opl <= '0;
            cen_opl <= 1'b0;
        end else begin
            cnt_opl <= (cnt_opl == OPL_LAST) ? '0 : cnt_opl + 1'b1;
            cen_opl <= (cnt_opl == OPL_LAST);
        end
    end

    // OPN at 1.5 MHz
    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            cnt_opn <= '0;
            cen_opn <= 1'b0;
        end else begin
            cnt_opn <= (cnt_opn == OPN_LAST) ? '0 : cnt_opn + 1'b1;
            cen_opn <= (cnt_opn == OPN_LAST);
        end
    end

    // MCU at 8 MHz, divide by three
    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            cnt_mcu <= '0;
            cen_mcu <= 1'b0;
        end else begin
            cnt_mcu <= (cnt_mcu == MCU_LAST) ? '0 : cnt_mcu + 1'b1;
            cen_mcu <= (cnt_mcu == MCU_LAST);
        end
    end

endmodule

//--- rtl/cop_pkg.sv
/* Shared vector types for the coprocessor glue */
package cop_pkg;

    // One MCU port, or one status byte
    typedef logic [7:0] byte_t;

    // Main CPU data word, as seen through the MCU latch
    typedef logic [15:0] word_t;

    // CPU to MCU select lines
    // Bit 0 raises the interrupt, bits 5:3 feed port 3
    typedef logic [5:0] sec_t;

    // Two-bit ROM bank flag fields
    // Sound bank, BG1 bank and mixer flags
    typedef logic [1:0] flag2_t;

    // CRT back colour
    typedef logic [2:0] crback_t;

    // Status dump source code
    // 0 video, 1 sound latch, 2 main, 3 sound
    typedef logic [1:0] st_sel_t;

endpackage

//--- rtl/cop_defines.svh
/* Board constants for the coprocessor glue
   Clock divide ratios, MCU port 2 strobe positions and status selector field */
`ifndef COP_DEFINES_SVH
`define COP_DEFINES_SVH

// Divide ratios from the 24 MHz clock
`define COP_DIV_OPL 8
`define COP_DIV_OPN 16
`define COP_DIV_MCU 3

// Port 2 bit positions
// Bit 2 goes back to the CPU as sec2
`define COP_P2_SEL2 2
// Interrupt acknowledge, active low
`define COP_P2_IRQ_ACK 3
// Data strobes, all active low
`define COP_P2_RDHI 4
`define COP_P2_RDLO 5
`define COP_P2_WRLO 6
`define COP_P2_WRHI 7

// Status dump address bits that pick the source
`define COP_ST_SEL_MSB 7
`define COP_ST_SEL_LSB 6

`endif
